// ==== Makefile ====
# Verilator build and run of the reservation station testbench

VERILATOR ?= verilator
TOP ?= rs_tb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
TESTS ?= tests/rs_tests.txt
PASS_MSG ?= Test passed
FAIL_MSG ?= Test failed
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(wildcard source/*.sv tests/*.sv)
BIN := $(OBJ_DIR)/$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) -f $(FILELIST)

run: $(BIN) $(TESTS)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== source/rs_entry_table.sv ====
/*
 * Entry storage and next-state merge of the reservation station.
 * Selection uses stored ready bits only, so wakeup costs one cycle.
 * Issue outputs are registered, one pulse per granted entry.
 */
`timescale 1ns/1ps

module rs_entry_table (
	input  logic clock,
	input  logic rst_n,
	input  logic flush,
	input  logic dispatch_valid,
	input  rs_pkg::fu_class_t dispatch_class,
	input  rs_pkg::op_t dispatch_op,
	input  rs_pkg::tag_t dispatch_dest,
	input  rs_pkg::tag_t dispatch_src1,
	input  logic dispatch_src1_ready,
	input  rs_pkg::tag_t dispatch_src2,
	input  logic dispatch_src2_ready,
	input  logic mem_busy,
	input  rs_pkg::entry_vec_t src1_hit,
	input  rs_pkg::entry_vec_t src2_hit,
	input  logic dispatch_src1_hit,
	input  logic dispatch_src2_hit,
	input  rs_pkg::entry_vec_t free_gnt,
	input  logic free_any,
	input  rs_pkg::entry_vec_t [rs_pkg::num_fu-1:0] select_gnt,
	output rs_pkg::tag_t [rs_pkg::rs_size-1:0] src1_tags,
	output rs_pkg::tag_t [rs_pkg::rs_size-1:0] src2_tags,
	output rs_pkg::entry_vec_t free_req,
	output rs_pkg::entry_vec_t [rs_pkg::num_fu-1:0] select_req,
	output rs_pkg::fu_vec_t issue_valid,
	output rs_pkg::op_t [rs_pkg::num_fu-1:0] issue_op,
	output rs_pkg::tag_t [rs_pkg::num_fu-1:0] issue_dest,
	output rs_pkg::tag_t [rs_pkg::num_fu-1:0] issue_src1,
	output rs_pkg::tag_t [rs_pkg::num_fu-1:0] issue_src2,
	output logic rs_full
);
	import rs_pkg::*;

	// Per-entry view of the busy and ready bits
	typedef enum logic [1:0] {
		st_free,
		st_wait,
		st_ready
	} entry_state_t;

	// Control state
	entry_vec_t busy;
	entry_vec_t src1_rdy;
	entry_vec_t src2_rdy;

	// Payload
	fu_class_t ent_class [rs_size];
	op_t ent_op [rs_size];
	tag_t ent_dest [rs_size];

	entry_state_t state [rs_size];
	entry_vec_t issued;
	entry_vec_t load;
	entry_vec_t busy_next;
	entry_vec_t src1_rdy_next;
	entry_vec_t src2_rdy_next;
	logic dispatch_accept;
	logic [idx_w-1:0] sel_idx [num_fu];

	// ------------------------------------------------------------
	// Request building
	// ------------------------------------------------------------

	always_comb begin
		for (int i = 0; i < rs_size; i++) begin
			if (!busy[i])
				state[i] = st_free;
			else if (src1_rdy[i] && src2_rdy[i])
				state[i] = st_ready;
			else
				state[i] = st_wait;
		end
	end

	// Any free slot may take the next dispatch
	assign free_req = ~busy;

	// Ready entries by class, MEM dropped while the unit is busy
	always_comb begin
		select_req = '0;
		for (int c = 0; c < num_fu; c++) begin
			for (int i = 0; i < rs_size; i++) begin
				select_req[c][i] = (state[i] == st_ready)
					&& (ent_class[i] == fu_class_t'(c))
					&& !(mem_busy && (ent_class[i] == fu_mem));
			end
		end
	end

	// ------------------------------------------------------------
	// Next-state merge
	// ------------------------------------------------------------

	// Entries leaving this cycle and their indices per class
	always_comb begin
		issued = '0;
		for (int c = 0; c < num_fu; c++) begin
			issued = issued | select_gnt[c];
			sel_idx[c] = onehot_to_idx(select_gnt[c]);
		end
	end

	assign dispatch_accept = dispatch_valid && free_any;
	assign load = dispatch_accept ? free_gnt : '0;

	// Issue and dispatch never hit the same slot
	assign busy_next = (busy & ~issued) | load;

	// New entry takes bypass, old entry accumulates hits while busy
	always_comb begin
		for (int i = 0; i < rs_size; i++) begin
			if (load[i]) begin
				src1_rdy_next[i] = dispatch_src1_ready || dispatch_src1_hit;
				src2_rdy_next[i] = dispatch_src2_ready || dispatch_src2_hit;
			end else begin
				src1_rdy_next[i] = src1_rdy[i] || (src1_hit[i] && busy[i]);
				src2_rdy_next[i] = src2_rdy[i] || (src2_hit[i] && busy[i]);
			end
		end
	end

	// Full from stored state only
	assign rs_full = &busy;

	// ------------------------------------------------------------
	// Registers
	// ------------------------------------------------------------

	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			busy <= '0;
			src1_rdy <= '0;
			src2_rdy <= '0;
			issue_valid <= '0;
		end else begin
			busy <= busy_next;
			src1_rdy <= src1_rdy_next;
			src2_rdy <= src2_rdy_next;
			for (int c = 0; c < num_fu; c++)
				issue_valid[c] <= |select_gnt[c];
		end
	end

	// Payload written only on dispatch or grant
	always_ff @(posedge clock) begin
		for (int i = 0; i < rs_size; i++) begin
			if (load[i]) begin
				ent_class[i] <= dispatch_class;
				ent_op[i] <= dispatch_op;
				ent_dest[i] <= dispatch_dest;
				src1_tags[i] <= dispatch_src1;
				src2_tags[i] <= dispatch_src2;
			end
		end
		for (int c = 0; c < num_fu; c++) begin
			if (|select_gnt[c]) begin
				issue_op[c] <= ent_op[sel_idx[c]];
				issue_dest[c] <= ent_dest[sel_idx[c]];
				issue_src1[c] <= src1_tags[sel_idx[c]];
				issue_src2[c] <= src2_tags[sel_idx[c]];
			end
		end
	end

endmodule

// ==== source/rs_pkg.sv ====
/*
 * Shared widths and types for the eight-entry reservation station.
 * Unit class 3 is reserved and never dispatched.
 * Entry and class vectors are plain bit vectors, one bit per slot.
 */
package rs_pkg;

	// ------------------------------------------------------------
	// Sizes
	// ------------------------------------------------------------

	// Number of window entries
	localparam int rs_size = 8;

	// Number of functional-unit classes (ALU, MULT, MEM)
	localparam int num_fu = 3;

	// Physical register tag width
	localparam int tag_w = 6;

	// Opcode payload width, passed through untouched
	localparam int op_w = 8;

	// Entry index width, log2 of rs_size
	localparam int idx_w = 3;

	// ------------------------------------------------------------
	// Types
	// ------------------------------------------------------------

	// Physical register tag
	typedef logic [tag_w-1:0] tag_t;

	// Opcode payload
	typedef logic [op_w-1:0] op_t;

	// Unit class, kept a plain vector so it can index per-class arrays
	typedef logic [1:0] fu_class_t;

	// One bit per entry
	typedef logic [rs_size-1:0] entry_vec_t;

	// One bit per unit class
	typedef logic [num_fu-1:0] fu_vec_t;

	// ------------------------------------------------------------
	// Unit class encoding
	// ------------------------------------------------------------

	localparam fu_class_t fu_alu = 2'd0;
	localparam fu_class_t fu_mult = 2'd1;
	localparam fu_class_t fu_mem = 2'd2;

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------

	// One-hot entry vector to binary index
	// Zero in gives index 0, caller qualifies with the vector's OR
	function automatic logic [idx_w-1:0] onehot_to_idx(input entry_vec_t v);
		logic [idx_w-1:0] idx;
		idx = '0;
		for (int i = 0; i < rs_size; i++) begin
			if (v[i]) begin
				idx = idx | idx_w'(i);
			end
		end
		return idx;
	endfunction

endpackage

// ==== source/rs_priority_pick.sv ====
/*
 * Fixed-priority picker, entry 0 has the highest priority.
 * Grant is one-hot or all zero.
 */
`timescale 1ns/1ps

module rs_priority_pick (
	input  rs_pkg::entry_vec_t req,
	output rs_pkg::entry_vec_t gnt,
	output logic any
);
	import rs_pkg::*;

	// Set once a lower-numbered request has been seen
	logic seen;

	// Ripple from index 0 upward
	always_comb begin
		gnt = '0;
		seen = 1'b0;
		for (int i = 0; i < rs_size; i++) begin
			gnt[i] = req[i] && !seen;
			seen = seen || req[i];
		end
	end

	// Any request present
	assign any = |req;

endmodule

// ==== source/rs_top.sv ====
/*
 * Reservation station top, eight entries and three unit classes.
 * Hold a dispatch while rs_full is high, it is dropped otherwise.
 * Issue is two cycles after the operands become ready.
 */
`timescale 1ns/1ps

module rs_top (
	input  logic clock,
	input  logic rst_n,
	input  logic flush,
	// Dispatch
	input  logic dispatch_valid,
	input  rs_pkg::fu_class_t dispatch_class,
	input  rs_pkg::op_t dispatch_op,
	input  rs_pkg::tag_t dispatch_dest,
	input  rs_pkg::tag_t dispatch_src1,
	input  logic dispatch_src1_ready,
	input  rs_pkg::tag_t dispatch_src2,
	input  logic dispatch_src2_ready,
	// Result broadcast
	input  logic cdb_valid,
	input  rs_pkg::tag_t cdb_tag,
	input  logic mem_busy,
	// Issue, one slot per class
	output rs_pkg::fu_vec_t issue_valid,
	output rs_pkg::op_t [rs_pkg::num_fu-1:0] issue_op,
	output rs_pkg::tag_t [rs_pkg::num_fu-1:0] issue_dest,
	output rs_pkg::tag_t [rs_pkg::num_fu-1:0] issue_src1,
	output rs_pkg::tag_t [rs_pkg::num_fu-1:0] issue_src2,
	output logic rs_full
);
	import rs_pkg::*;

	tag_t [rs_size-1:0] src1_tags;
	tag_t [rs_size-1:0] src2_tags;
	entry_vec_t src1_hit;
	entry_vec_t src2_hit;
	logic dispatch_src1_hit;
	logic dispatch_src2_hit;
	entry_vec_t free_req;
	entry_vec_t free_gnt;
	logic free_any;
	entry_vec_t [num_fu-1:0] select_req;
	entry_vec_t [num_fu-1:0] select_gnt;

	// ------------------------------------------------------------
	// Wakeup and pickers, side by side
	// ------------------------------------------------------------

	rs_wakeup_cam u_cam (
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.src1_tags(src1_tags),
		.src2_tags(src2_tags),
		.dispatch_src1(dispatch_src1),
		.dispatch_src2(dispatch_src2),
		.src1_hit(src1_hit),
		.src2_hit(src2_hit),
		.dispatch_src1_hit(dispatch_src1_hit),
		.dispatch_src2_hit(dispatch_src2_hit)
	);

	// Lowest free slot for dispatch
	rs_priority_pick u_free_pick (
		.req(free_req),
		.gnt(free_gnt),
		.any(free_any)
	);

	// One picker per unit class
	for (genvar c = 0; c < num_fu; c++) begin : g_select
		rs_priority_pick u_pick (
			.req(select_req[c]),
			.gnt(select_gnt[c]),
			.any()
		);
	end

	// ------------------------------------------------------------
	// Entry table
	// ------------------------------------------------------------

	rs_entry_table u_table (
		.clock(clock),
		.rst_n(rst_n),
		.flush(flush),
		.dispatch_valid(dispatch_valid),
		.dispatch_class(dispatch_class),
		.dispatch_op(dispatch_op),
		.dispatch_dest(dispatch_dest),
		.dispatch_src1(dispatch_src1),
		.dispatch_src1_ready(dispatch_src1_ready),
		.dispatch_src2(dispatch_src2),
		.dispatch_src2_ready(dispatch_src2_ready),
		.mem_busy(mem_busy),
		.src1_hit(src1_hit),
		.src2_hit(src2_hit),
		.dispatch_src1_hit(dispatch_src1_hit),
		.dispatch_src2_hit(dispatch_src2_hit),
		.free_gnt(free_gnt),
		.free_any(free_any),
		.select_gnt(select_gnt),
		.src1_tags(src1_tags),
		.src2_tags(src2_tags),
		.free_req(free_req),
		.select_req(select_req),
		.issue_valid(issue_valid),
		.issue_op(issue_op),
		.issue_dest(issue_dest),
		.issue_src1(issue_src1),
		.issue_src2(issue_src2),
		.rs_full(rs_full)
	);

endmodule

// ==== source/rs_wakeup_cam.sv ====
/*
 * Tag comparator for one result broadcast per cycle.
 * Hits ignore busy and ready state, the entry table qualifies them.
 */
`timescale 1ns/1ps

module rs_wakeup_cam (
	input  logic cdb_valid,
	input  rs_pkg::tag_t cdb_tag,
	input  rs_pkg::tag_t [rs_pkg::rs_size-1:0] src1_tags,
	input  rs_pkg::tag_t [rs_pkg::rs_size-1:0] src2_tags,
	input  rs_pkg::tag_t dispatch_src1,
	input  rs_pkg::tag_t dispatch_src2,
	output rs_pkg::entry_vec_t src1_hit,
	output rs_pkg::entry_vec_t src2_hit,
	output logic dispatch_src1_hit,
	output logic dispatch_src2_hit
);
	import rs_pkg::*;

	// Compare against every stored source tag
	always_comb begin
		src1_hit = '0;
		src2_hit = '0;
		for (int i = 0; i < rs_size; i++) begin
			src1_hit[i] = cdb_valid && (src1_tags[i] == cdb_tag);
			src2_hit[i] = cdb_valid && (src2_tags[i] == cdb_tag);
		end
	end

	// ------------------------------------------------------------
	// Dispatch bypass
	// ------------------------------------------------------------

	// Incoming instruction sees the same-cycle broadcast
	assign dispatch_src1_hit = cdb_valid && (dispatch_src1 == cdb_tag);
	assign dispatch_src2_hit = cdb_valid && (dispatch_src2 == cdb_tag);

endmodule

// ==== tb.f ====
source/rs_pkg.sv
source/rs_wakeup_cam.sv
source/rs_priority_pick.sv
source/rs_entry_table.sv
source/rs_top.sv
tests/rs_chk.sv
tests/rs_tb.sv

// ==== tests/rs_chk.sv ====
/*
 * Concurrent checks bound into every rs_entry_table instance.
 * Grant and full checks are off while rst_n is low.
 */
`timescale 1ns/1ps

module rs_chk (
	input logic clock,
	input logic rst_n,
	input logic dispatch_valid,
	input logic rs_full,
	input rs_pkg::entry_vec_t load,
	input rs_pkg::entry_vec_t [rs_pkg::num_fu-1:0] select_gnt,
	input rs_pkg::fu_vec_t issue_valid
);
	import rs_pkg::*;

	// At most one entry granted per class
	for (genvar c = 0; c < num_fu; c++) begin : g_gnt
		a_gnt_onehot: assert property (@(posedge clock) disable iff (!rst_n)
			$onehot0(select_gnt[c]))
			else $error("Class %0d grant has more than one bit set", c);
	end

	// Full window takes nothing
	a_no_load_full: assert property (@(posedge clock) disable iff (!rst_n)
		(dispatch_valid && rs_full) |-> (load == '0))
		else $error("Dispatch written while the window is full");

	// First cycle out of reset is idle
	a_idle_after_reset: assert property (@(posedge clock)
		(!$past(rst_n) && rst_n) |-> (issue_valid == '0))
		else $error("Issue valid set in the first cycle after reset");

endmodule

bind rs_entry_table rs_chk u_chk (
	.clock(clock),
	.rst_n(rst_n),
	.dispatch_valid(dispatch_valid),
	.rs_full(rs_full),
	.load(load),
	.select_gnt(select_gnt),
	.issue_valid(issue_valid)
);

// ==== tests/rs_tb.sv ====
/*
 * Testbench for rs_top, one record of tests/rs_tests.txt per clock cycle.
 * Run from the project root so the relative data path resolves.
 * Expected columns describe the outputs seen in the record's own cycle.
 */
`timescale 1ns/1ps

module rs_tb;
	import rs_pkg::*;

	// Clock period and input skew in ns
	localparam int clk_period = 4;
	localparam int drive_delay = 1;
	localparam int reset_cycles = 3;
	localparam int num_fields = 20;
	localparam string test_file = "tests/rs_tests.txt";

	logic clock;
	logic rst_n;
	logic flush;
	logic dispatch_valid;
	fu_class_t dispatch_class;
	op_t dispatch_op;
	tag_t dispatch_dest;
	tag_t dispatch_src1;
	logic dispatch_src1_ready;
	tag_t dispatch_src2;
	logic dispatch_src2_ready;
	logic cdb_valid;
	tag_t cdb_tag;
	logic mem_busy;
	fu_vec_t issue_valid;
	op_t [num_fu-1:0] issue_op;
	tag_t [num_fu-1:0] issue_dest;
	tag_t [num_fu-1:0] issue_src1;
	tag_t [num_fu-1:0] issue_src2;
	logic rs_full;

	// One packed record per cycle, byte k holds column k
	logic [num_fields*8-1:0] records [$];
	int errors;
	int checks;
	bit loaded;

	rs_top uut (
		.clock(clock),
		.rst_n(rst_n),
		.flush(flush),
		.dispatch_valid(dispatch_valid),
		.dispatch_class(dispatch_class),
		.dispatch_op(dispatch_op),
		.dispatch_dest(dispatch_dest),
		.dispatch_src1(dispatch_src1),
		.dispatch_src1_ready(dispatch_src1_ready),
		.dispatch_src2(dispatch_src2),
		.dispatch_src2_ready(dispatch_src2_ready),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.mem_busy(mem_busy),
		.issue_valid(issue_valid),
		.issue_op(issue_op),
		.issue_dest(issue_dest),
		.issue_src1(issue_src1),
		.issue_src2(issue_src2),
		.rs_full(rs_full)
	);

	initial begin
		clock = 1'b0;
		forever #(clk_period / 2) clock = ~clock;
	end

	// ------------------------------------------------------------
	// Record access
	// ------------------------------------------------------------

	function automatic logic [7:0] rec_field(input logic [num_fields*8-1:0] rec, input int k);
		return rec[k*8 +: 8];
	endfunction

	// Source tags of the latest earlier dispatch with this op and dest
	function automatic bit find_sources(input int idx, input op_t op, input tag_t dest,
		output tag_t src1, output tag_t src2);
		bit found;
		found = 1'b0;
		src1 = '0;
		src2 = '0;
		for (int j = 0; j < idx; j++) begin
			if (1'(rec_field(records[j], 0))
				&& op_t'(rec_field(records[j], 2)) == op
				&& tag_t'(rec_field(records[j], 3)) == dest) begin
				found = 1'b1;
				src1 = tag_t'(rec_field(records[j], 4));
				src2 = tag_t'(rec_field(records[j], 6));
			end
		end
		return found;
	endfunction

	// Read all records up front, so the run length is known
	task automatic load_records();
		int fd;
		int n;
		int line_no;
		int f [num_fields];
		string line;
		logic [num_fields*8-1:0] rec;
		fd = $fopen(test_file, "r");
		if (fd == 0) begin
			$display("Could not open stimulus file %s", test_file);
			errors++;
			return;
		end
		line_no = 0;
		while ($fgets(line, fd) != 0) begin
			line_no++;
			// Blank lines and column notes
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
				f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
			if (n != num_fields) begin
				$display("Line %0d of %s is not a complete record", line_no, test_file);
				errors++;
			end else begin
				for (int k = 0; k < num_fields; k++)
					rec[k*8 +: 8] = f[k][7:0];
				records.push_back(rec);
			end
		end
		$fclose(fd);
		if (records.size() == 0) begin
			$display("Stimulus file %s holds no records", test_file);
			errors++;
		end
	endtask

	// Dispatch, CDB, mem_busy and flush columns
	task automatic apply_record(input logic [num_fields*8-1:0] rec);
		dispatch_valid = 1'(rec_field(rec, 0));
		dispatch_class = fu_class_t'(rec_field(rec, 1));
		dispatch_op = op_t'(rec_field(rec, 2));
		dispatch_dest = tag_t'(rec_field(rec, 3));
		dispatch_src1 = tag_t'(rec_field(rec, 4));
		dispatch_src1_ready = 1'(rec_field(rec, 5));
		dispatch_src2 = tag_t'(rec_field(rec, 6));
		dispatch_src2_ready = 1'(rec_field(rec, 7));
		cdb_valid = 1'(rec_field(rec, 8));
		cdb_tag = tag_t'(rec_field(rec, 9));
		mem_busy = 1'(rec_field(rec, 10));
		flush = 1'(rec_field(rec, 11));
	endtask

	// Op, dest and source tags compared only for classes expected valid
	task automatic check_outputs(input logic [num_fields*8-1:0] rec, input int idx);
		fu_vec_t exp_valid;
		op_t exp_op;
		tag_t exp_dest;
		tag_t exp_src1;
		tag_t exp_src2;
		logic exp_full;
		exp_valid = fu_vec_t'(rec_field(rec, 12));
		exp_full = 1'(rec_field(rec, 19));
		checks++;
		if (issue_valid !== exp_valid) begin
			$display("CHECK FAILED at %0d ns: record %0d issue_valid %b, expected %b",
				$time, idx, issue_valid, exp_valid);
			errors++;
		end
		for (int c = 0; c < num_fu; c++) begin
			exp_op = op_t'(rec_field(rec, 13 + 2 * c));
			exp_dest = tag_t'(rec_field(rec, 14 + 2 * c));
			if (exp_valid[c]) begin
				checks++;
				if (issue_op[c] !== exp_op || issue_dest[c] !== exp_dest) begin
					$display("CHECK FAILED at %0d ns: record %0d class %0d op %h dest %h, expected %h %h",
						$time, idx, c, issue_op[c], issue_dest[c], exp_op, exp_dest);
					errors++;
				end
				// Source tags travel with the dispatched instruction
				checks++;
				if (!find_sources(idx, exp_op, exp_dest, exp_src1, exp_src2)) begin
					$display("Record %0d expects op %h dest %h, which no earlier record dispatches",
						idx, exp_op, exp_dest);
					errors++;
				end else if (issue_src1[c] !== exp_src1 || issue_src2[c] !== exp_src2) begin
					$display("CHECK FAILED at %0d ns: record %0d class %0d src %h %h, expected %h %h",
						$time, idx, c, issue_src1[c], issue_src2[c], exp_src1, exp_src2);
					errors++;
				end
			end
		end
		checks++;
		if (rs_full !== exp_full) begin
			$display("CHECK FAILED at %0d ns: record %0d rs_full %b, expected %b",
				$time, idx, rs_full, exp_full);
			errors++;
		end
	endtask

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------

	initial begin
		errors = 0;
		checks = 0;
		loaded = 1'b0;
		rst_n = 1'b0;
		flush = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_class = fu_alu;
		dispatch_op = '0;
		dispatch_dest = '0;
		dispatch_src1 = '0;
		dispatch_src1_ready = 1'b0;
		dispatch_src2 = '0;
		dispatch_src2_ready = 1'b0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		mem_busy = 1'b0;
		load_records();
		loaded = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		#drive_delay;
		rst_n = 1'b1;
		// Outputs are registered, so check first and then drive
		foreach (records[i]) begin
			check_outputs(records[i], i);
			apply_record(records[i]);
			@(posedge clock);
			#drive_delay;
		end
		$display("Done: %0d errors in %0d checks over %0d records",
			errors, checks, records.size());
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Watchdog, sized from the record count
	initial begin
		wait (loaded);
		#((records.size() + 20) * clk_period);
		$display("Watchdog expired before the records were finished");
		$display("Test failed");
		$finish;
	end

endmodule

// ==== tests/rs_tests.txt ====
# Hex, one cycle per line: dv cls op dest s1 r1 s2 r2 cv ctag mb fl
#   then expected: issue_valid op_alu dest_alu op_mult dest_mult op_mem dest_mem rs_full
1 0 11 01 00 1 00 1 0 00 0 0   0 00 00 00 00 00 00 0
1 1 21 02 00 1 00 1 0 00 0 0   0 00 00 00 00 00 00 0
1 2 31 03 00 1 00 1 0 00 0 0   1 11 01 00 00 00 00 0
1 0 12 04 10 0 01 1 0 00 0 0   2 00 00 21 02 00 00 0
1 0 13 05 11 0 01 1 1 11 0 0   4 00 00 00 00 31 03 0
0 0 00 00 00 0 00 0 1 10 0 0   0 00 00 00 00 00 00 0
0 0 00 00 00 0 00 0 0 00 0 0   1 13 05 00 00 00 00 0
1 0 41 06 20 0 02 1 0 00 0 0   1 12 04 00 00 00 00 0
1 0 42 07 20 0 02 1 0 00 0 0   0 00 00 00 00 00 00 0
1 0 43 08 20 0 02 1 0 00 0 0   0 00 00 00 00 00 00 0
1 1 51 09 20 0 02 1 0 00 0 0   0 00 00 00 00 00 00 0
1 2 61 0a 20 0 02 1 1 20 0 0   0 00 00 00 00 00 00 0
0 0 00 00 00 0 00 0 0 00 0 0   0 00 00 00 00 00 00 0
1 2 62 0b 00 1 00 1 0 00 1 0   7 41 06 51 09 61 0a 0
0 0 00 00 00 0 00 0 0 00 1 0   1 42 07 00 00 00 00 0
0 0 00 00 00 0 00 0 0 00 1 0   1 43 08 00 00 00 00 0
0 0 00 00 00 0 00 0 0 00 0 0   0 00 00 00 00 00 00 0
1 0 71 10 31 0 03 1 0 00 0 0   4 00 00 00 00 62 0b 0
1 0 72 11 30 0 03 1 0 00 0 0   0 00 00 00 00 00 00 0
1 0 73 12 30 0 03 1 0 00 0 0   0 00 00 00 00 00 00 0
1 0 74 13 30 0 03 1 0 00 0 0   0 00 00 00 00 00 00 0
1 0 75 14 30 0 03 1 0 00 0 0   0 00 00 00 00 00 00 0
1 0 76 15 30 0 03 1 0 00 0 0   0 00 00 00 00 00 00 0
1 0 77 16 30 0 03 1 0 00 0 0   0 00 00 00 00 00 00 0
1 0 78 17 30 0 03 1 0 00 0 0   0 00 00 00 00 00 00 0
1 1 81 18 01 1 02 1 0 00 0 0   0 00 00 00 00 00 00 1
1 1 81 18 01 1 02 1 1 31 0 0   0 00 00 00 00 00 00 1
1 1 81 18 01 1 02 1 0 00 0 0   0 00 00 00 00 00 00 1
1 1 81 18 01 1 02 1 0 00 0 0   1 71 10 00 00 00 00 0
0 0 00 00 00 0 00 0 0 00 0 0   0 00 00 00 00 00 00 1
0 0 00 00 00 0 00 0 0 00 0 1   2 00 00 81 18 00 00 0
0 0 00 00 00 0 00 0 1 30 0 0   0 00 00 00 00 00 00 0
1 0 91 19 00 1 00 1 1 30 0 0   0 00 00 00 00 00 00 0
0 0 00 00 00 0 00 0 0 00 0 0   0 00 00 00 00 00 00 0
0 0 00 00 00 0 00 0 0 00 0 0   1 91 19 00 00 00 00 0
0 0 00 00 00 0 00 0 0 00 0 0   0 00 00 00 00 00 00 0
